// ==== verilog/banked_sram_pkg.sv ====
package banked_sram_pkg;

  // ********************************************************************
  // widths and depths
  // ********************************************************************

  localparam int unsigned ADDR_WIDTH      = 32;  // byte address.
  localparam int unsigned DATA_WIDTH      = 64;
  localparam int unsigned NUM_BANKS       = 4;
  localparam int unsigned BANK_DATA_WIDTH = DATA_WIDTH / NUM_BANKS;
  localparam int unsigned BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;
  localparam int unsigned STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int unsigned BANK_WORDS      = 64;

  // each bank gets its own request and response queue of this depth.
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned MAX_TRANS  = 4;  // wide requests in flight.

  // ********************************************************************
  // types
  // ********************************************************************

  typedef logic [ADDR_WIDTH-1:0]      addr_t;
  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [STRB_WIDTH-1:0]      strb_t;
  typedef logic [BANK_DATA_WIDTH-1:0] bank_data_t;
  typedef logic [BANK_STRB_WIDTH-1:0] bank_strb_t;
  typedef logic [NUM_BANKS-1:0]       bank_mask_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // one slice of a wide request, as it waits in a bank queue.
  typedef struct packed {
    addr_t      addr;
    bank_data_t wdata;
    bank_strb_t strb;
    mem_op_e    op;
  } bank_req_t;

endpackage

// ==== verilog/bank_if.sv ====
`timescale 1ns/1ps

interface bank_if;
  import banked_sram_pkg::*;

  // request side, driven by the splitter.
  logic       req;
  addr_t      addr;
  bank_data_t wdata;
  bank_strb_t strb;
  mem_op_e    op;

  // grant and response, driven by the bank.
  logic       gnt;
  logic       rvalid;
  bank_data_t rdata;

  modport splitter (
    output req, addr, wdata, strb, op,
    input  gnt, rvalid, rdata
  );

  modport bank (
    input  req, addr, wdata, strb, op,
    output gnt, rvalid, rdata
  );

endinterface

// ==== verilog/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
  parameter int unsigned DEPTH        = 2,
  parameter bit          FALL_THROUGH = 1'b0,
  parameter type         T            = logic
) (
  input  logic clk_i,
  input  logic reset_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  localparam int unsigned PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_WIDTH = $clog2(DEPTH + 1);

  T mem [DEPTH];

  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [CNT_WIDTH-1:0] count;
  logic                 empty;
  logic                 full;
  logic                 pass_thru;
  logic                 push;
  logic                 pop;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty     = (count == '0);
  assign full      = (count == CNT_WIDTH'(DEPTH));
  assign pass_thru = FALL_THROUGH && empty;  // input shows on the output at once.
  assign ready_o   = ~full;

  always_comb begin
    if (pass_thru) begin
      data_o  = data_i;
      valid_o = valid_i;
    end else begin
      data_o  = mem[rd_ptr];
      valid_o = ~empty;
    end
  end

  // a word taken straight through is never stored.
  assign push = valid_i & ~full & ~(pass_thru & ready_i);
  assign pop  = ~empty & ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr] <= data_i;
  end

endmodule

// ==== verilog/bank_splitter.sv ====
`timescale 1ns/1ps

module bank_splitter (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_i,
  output logic                    gnt_o,
  input  banked_sram_pkg::addr_t  addr_i,
  input  banked_sram_pkg::data_t  wdata_i,
  input  banked_sram_pkg::strb_t  strb_i,
  input  banked_sram_pkg::mem_op_e op_i,
  output logic                    rvalid_o,
  output banked_sram_pkg::data_t  rdata_o,
  bank_if.splitter                banks [banked_sram_pkg::NUM_BANKS]
);
  import banked_sram_pkg::*;

  localparam int unsigned CNT_WIDTH   = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned ALIGN_SHIFT = $clog2(STRB_WIDTH);

  logic       accept;
  bank_mask_t req_ready;
  bank_mask_t resp_ready;
  bank_mask_t resp_valid;
  bank_mask_t resp_pop;
  bank_mask_t zero_strb;   // write slices that never reach their bank.
  bank_mask_t dead_mask;
  bank_mask_t dead_resp;
  logic       dead_valid;
  logic       dead_ready;

  function automatic addr_t align_addr(input addr_t addr);
    return (addr >> ALIGN_SHIFT) << ALIGN_SHIFT;
  endfunction

  assign accept = req_i & gnt_o;

  // any full queue stops new wide requests.
  assign gnt_o = (&req_ready) & (&resp_ready) & dead_ready;

  // ********************************************************************
  // per-bank request path
  // ********************************************************************

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    bank_req_t            slice;
    bank_req_t            head;
    logic                 head_valid;
    logic                 head_pop;
    logic                 hidden;
    logic                 credit_ok;
    logic                 issued;
    logic [CNT_WIDTH-1:0] pending;  // requests in the bank plus queued responses.

    assign slice.addr  = align_addr(addr_i) + ADDR_WIDTH'(i * BANK_STRB_WIDTH);
    assign slice.wdata = wdata_i[i*BANK_DATA_WIDTH +: BANK_DATA_WIDTH];
    assign slice.strb  = strb_i[i*BANK_STRB_WIDTH +: BANK_STRB_WIDTH];
    assign slice.op    = op_i;

    assign zero_strb[i] = (op_i == OP_WRITE) && (slice.strb == '0);

    stream_fifo #(
      .DEPTH        (FIFO_DEPTH),
      .FALL_THROUGH (1'b1),
      .T            (bank_req_t)
    ) u_req_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .data_i  (slice),
      .valid_i (accept),
      .ready_o (req_ready[i]),
      .data_o  (head),
      .valid_o (head_valid),
      .ready_i (head_pop)
    );

    assign hidden    = (head.op == OP_WRITE) && (head.strb == '0);
    assign credit_ok = (pending < CNT_WIDTH'(FIFO_DEPTH));

    // a hidden write leaves the queue without a bank access.
    assign banks[i].req   = head_valid & ~hidden & credit_ok;
    assign banks[i].addr  = head.addr;
    assign banks[i].wdata = head.wdata;
    assign banks[i].strb  = head.strb;
    assign banks[i].op    = head.op;

    assign head_pop = hidden | (banks[i].gnt & credit_ok);
    assign issued   = banks[i].req & banks[i].gnt;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        pending <= '0;
      end else if (issued && !resp_pop[i]) begin
        pending <= pending + 1'b1;
      end else if (resp_pop[i] && !issued) begin
        pending <= pending - 1'b1;
      end
    end

    stream_fifo #(
      .DEPTH        (FIFO_DEPTH),
      .FALL_THROUGH (1'b1),
      .T            (bank_data_t)
    ) u_resp_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .data_i  (banks[i].rdata),
      .valid_i (banks[i].rvalid),
      .ready_o (resp_ready[i]),
      .data_o  (rdata_o[i*BANK_DATA_WIDTH +: BANK_DATA_WIDTH]),
      .valid_o (resp_valid[i]),
      .ready_i (resp_pop[i])
    );

    assign resp_pop[i] = rvalid_o & ~dead_resp[i];  // dead lanes hold no response.
  end

  // ********************************************************************
  // missing responses and merge
  // ********************************************************************

  // one entry per wide request, so the head always matches the oldest one.
  stream_fifo #(
    .DEPTH        (MAX_TRANS + 1),
    .FALL_THROUGH (1'b0),
    .T            (bank_mask_t)
  ) u_dead_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (zero_strb),
    .valid_i (accept),
    .ready_o (dead_ready),
    .data_o  (dead_mask),
    .valid_o (dead_valid),
    .ready_i (rvalid_o)
  );

  assign dead_resp = dead_mask & {NUM_BANKS{dead_valid}};
  assign rvalid_o  = &(resp_valid | dead_resp);

endmodule

// ==== verilog/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank (
  input  logic clk_i,
  input  logic reset_i,
  input  logic stall_i,
  bank_if.bank bus
);
  import banked_sram_pkg::*;

  localparam int unsigned IDX_WIDTH = $clog2(BANK_WORDS);
  localparam int unsigned IDX_LSB   = $clog2(STRB_WIDTH);

  bank_data_t           mem [BANK_WORDS];
  logic [IDX_WIDTH-1:0] idx;
  logic                 fire;
  logic                 rvalid_q;
  bank_data_t           rdata_q;

  // the word index comes from the wide address, so higher bits wrap.
  assign idx  = bus.addr[IDX_LSB +: IDX_WIDTH];
  assign fire = bus.req & bus.gnt;

  assign bus.gnt = ~stall_i;  // contention is modelled from outside.

  always_ff @(posedge clk_i) begin
    if (fire) begin
      rdata_q <= mem[idx];  // write responses carry the old word.
      if (bus.op == OP_WRITE) begin
        for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
          if (bus.strb[b]) mem[idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= fire;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

endmodule

// ==== verilog/banked_sram.sv ====
`timescale 1ns/1ps

module banked_sram (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    req_i,
  output logic                                    gnt_o,
  input  logic [banked_sram_pkg::ADDR_WIDTH-1:0]  addr_i,
  input  logic [banked_sram_pkg::DATA_WIDTH-1:0]  wdata_i,
  input  logic [banked_sram_pkg::STRB_WIDTH-1:0]  strb_i,
  input  logic                                    we_i,
  input  logic [banked_sram_pkg::NUM_BANKS-1:0]   bank_stall_i,
  output logic                                    rvalid_o,
  output logic [banked_sram_pkg::DATA_WIDTH-1:0]  rdata_o
);
  import banked_sram_pkg::*;

  mem_op_e op;

  bank_if bank_bus [NUM_BANKS] ();

  assign op = we_i ? OP_WRITE : OP_READ;

  // ********************************************************************
  // splitter and banks
  // ********************************************************************

  bank_splitter u_splitter (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .gnt_o    (gnt_o),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .strb_i   (strb_i),
    .op_i     (op),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .banks    (bank_bus)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    sram_bank u_bank (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .stall_i (bank_stall_i[i]),
      .bus     (bank_bus[i])
    );
  end

endmodule

// ==== verif/banked_sram_tb_checks.svh ====
`ifndef BANKED_SRAM_TB_CHECKS_SVH
`define BANKED_SRAM_TB_CHECKS_SVH

// ********************************************************************
// reference memory
// ********************************************************************

logic [7:0] model_mem [512];  // one entry per byte, 64 wide words.

function automatic int unsigned model_base(input addr_t a);
  return int'(a[8:3]) * STRB_WIDTH;  // higher address bits wrap.
endfunction

task automatic model_write(input addr_t a, input data_t d, input strb_t s);
  int unsigned base;
  base = model_base(a);
  for (int j = 0; j < STRB_WIDTH; j++) begin
    if (s[j]) model_mem[base + j] = d[j*8 +: 8];
  end
endtask

function automatic data_t model_read(input addr_t a);
  data_t       d;
  int unsigned base;
  base = model_base(a);
  for (int j = 0; j < STRB_WIDTH; j++) begin
    d[j*8 +: 8] = model_mem[base + j];
  end
  return d;
endfunction

// ********************************************************************
// compare tasks
// ********************************************************************

task automatic fail_now(input string what);
  $display("%s", what);
  $display("Something failed");
  $fatal(1, "stopped at the first error");
endtask

task automatic check_data(input string name, input data_t actual, input data_t expected);
  if (actual !== expected) begin
    fail_now($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected));
  end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
  if (actual !== expected) begin
    fail_now($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected));
  end
endtask

// ********************************************************************
// request and response helpers
// ********************************************************************

// waits for the falling edge and takes the response of the cycle that ends there.
task automatic next_cycle();
  int unsigned lat;
  data_t       exp_word;
  bit          is_read;
  @(negedge clk);
  if (rvalid === 1'b1) begin
    if (exp_data_q.size() == 0) begin
      fail_now("rvalid_o went high with no request outstanding");
    end
    lat      = cycle_count - exp_cycle_q.pop_front();
    exp_word = exp_data_q.pop_front();
    is_read  = exp_read_q.pop_front();
    if (strict_latency && lat != 1) begin
      fail_now($sformatf("a response came %0d cycles after acceptance instead of 1", lat));
    end
    if (is_read) check_data("rdata_o", rdata, exp_word);
    response_count++;
  end else begin
    check_bit("rvalid_o", rvalid, 1'b0);
  end
  if (random_stall) begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      bank_stall[i] = (($urandom % 4) == 0);
    end
  end
endtask

// drives one request for one cycle and records it when the DUT grants it.
task automatic offer(input bit is_write, input addr_t a, input data_t d, input strb_t s,
                     output bit taken);
  data_t exp_word;
  next_cycle();
  req   = 1'b1;
  we    = is_write;
  addr  = a;
  wdata = d;
  strb  = s;
  taken = (gnt === 1'b1);  // gnt_o follows queue state only, so it holds until the edge.
  if (taken) begin
    exp_word = is_write ? '0 : model_read(a);
    exp_read_q.push_back(!is_write);
    exp_data_q.push_back(exp_word);
    exp_cycle_q.push_back(cycle_count);
    if (is_write) model_write(a, d, s);
    accepted_count++;
  end
endtask

task automatic issue(input bit is_write, input addr_t a, input data_t d, input strb_t s);
  bit taken;
  do begin
    offer(is_write, a, d, s, taken);
  end while (!taken);
endtask

task automatic idle_cycle();
  next_cycle();
  req = 1'b0;
endtask

// waits for the outstanding responses, but gives up after DRAIN_CYCLES idle cycles.
task automatic drain();
  int unsigned waited;
  waited = 0;
  do begin
    idle_cycle();
    waited++;
  end while (exp_data_q.size() != 0 && waited < DRAIN_CYCLES);
endtask

`endif

// ==== verif/banked_sram_tb.sv ====
`timescale 1ns/1ps

module banked_sram_tb;
  import banked_sram_pkg::*;

  localparam int unsigned HALF_PERIOD = 10;  // 20 ns clock.
  localparam int unsigned RANDOM_SEED = 32'h8725f8e7;
  localparam int unsigned RANDOM_OPS  = 300;
  // fill and directed tests need about 200 cycles, the stalled random mix about 1300.
  localparam int unsigned TIMEOUT_CYCLES = 4000;
  localparam int unsigned DRAIN_CYCLES   = 32;  // longest wait for the last responses.

  logic       clk;
  logic       reset;
  logic       req;
  logic       gnt;
  addr_t      addr;
  data_t      wdata;
  strb_t      strb;
  logic       we;
  bank_mask_t bank_stall;
  logic       rvalid;
  data_t      rdata;

  // expected responses, oldest first.
  data_t       exp_data_q [$];
  bit          exp_read_q [$];
  int unsigned exp_cycle_q [$];

  int unsigned cycle_count = 0;
  int unsigned accepted_count;
  int unsigned response_count;
  bit          strict_latency;  // no stalls, so every response takes one cycle.
  bit          random_stall;

  `include "banked_sram_tb_checks.svh"

  banked_sram u_dut (
    .clk_i        (clk),
    .reset_i      (reset),
    .req_i        (req),
    .gnt_o        (gnt),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .strb_i       (strb),
    .we_i         (we),
    .bank_stall_i (bank_stall),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_now($sformatf("timeout, the tests did not finish in %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // every byte of the fill depends on its whole byte index.
  function automatic data_t fill_word(input int unsigned w);
    data_t       d;
    int unsigned k;
    for (int j = 0; j < STRB_WIDTH; j++) begin
      k = w * STRB_WIDTH + j;
      d[j*8 +: 8] = 8'(k * 37) ^ 8'(k >> 3);
    end
    return d;
  endfunction

  // ********************************************************************
  // directed tests
  // ********************************************************************

  task automatic test_reset_state();
    check_bit("rvalid_o", rvalid, 1'b0);
    check_bit("gnt_o", gnt, 1'b1);
  endtask

  task automatic fill_memory();
    strict_latency = 1'b1;
    for (int w = 0; w < BANK_WORDS; w++) begin
      issue(1'b1, addr_t'(w * STRB_WIDTH), fill_word(w), '1);
    end
    drain();
  endtask

  task automatic test_full_word();
    issue(1'b1, 32'h0000_0040, 64'h0123_4567_89ab_cdef, 8'hff);
    issue(1'b0, 32'h0000_0040, '0, '0);
    issue(1'b1, 32'h0000_01f8, 64'hfedc_ba98_7654_3210, 8'hff);
    issue(1'b0, 32'h0000_01f8, '0, '0);
    issue(1'b0, 32'h0000_0045, '0, '0);  // unaligned, same word as 0x40.
    issue(1'b0, 32'h1000_0040, '0, '0);  // high bits wrap.
    drain();
  endtask

  task automatic test_partial_strobes();
    issue(1'b1, 32'h0000_0080, 64'h1111_2222_3333_4444, 8'h0f);
    issue(1'b1, 32'h0000_0080, 64'haaaa_bbbb_cccc_dddd, 8'ha5);
    issue(1'b1, 32'h0000_0088, 64'h5555_6666_7777_8888, 8'h3c);
    issue(1'b0, 32'h0000_0080, '0, '0);
    issue(1'b0, 32'h0000_0088, '0, '0);
    drain();
  endtask

  task automatic test_zero_strobe_banks();
    issue(1'b1, 32'h0000_00c0, 64'hdead_beef_cafe_f00d, 8'hc3);  // banks 1 and 2 hidden.
    issue(1'b1, 32'h0000_00c8, 64'h0bad_0bad_0bad_0bad, 8'h00);
    issue(1'b1, 32'h0000_00d0, 64'h1234_5678_9abc_def0, 8'h0c);
    issue(1'b0, 32'h0000_00c0, '0, '0);
    issue(1'b0, 32'h0000_00c8, '0, '0);
    issue(1'b0, 32'h0000_00d0, '0, '0);
    drain();
  endtask

  task automatic test_back_pressure();
    int unsigned k;
    int unsigned accepted_before;
    int unsigned responses_before;
    bit          taken;
    k                = 0;
    accepted_before  = accepted_count;
    responses_before = response_count;
    strict_latency   = 1'b0;
    bank_stall       = 4'b0100;
    // each read follows a write to the same word, so order matters.
    for (int n = 0; k < 16; n++) begin
      offer(k % 2 == 0, addr_t'(32'h100 + ((k / 2) % 4) * 8),
            {16'h5a5a, 16'(k), 16'hc3c3, 16'(k * 3)},
            (k % 4 == 2) ? 8'h3c : 8'hff, taken);
      if (taken) k++;
      if (n == 9) begin
        check_bit("gnt_o", gnt, 1'b0);
        bank_stall = '0;
      end
    end
    drain();
    if (accepted_count - accepted_before != response_count - responses_before) begin
      fail_now($sformatf("%0d requests were accepted but %0d responses came back",
                         accepted_count - accepted_before, response_count - responses_before));
    end
  endtask

  task automatic test_random_mix();
    bit    is_write;
    addr_t a;
    data_t d;
    strb_t s;
    strict_latency = 1'b0;
    random_stall   = 1'b1;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      is_write = 1'($urandom);
      a        = $urandom;
      d        = {$urandom, $urandom};
      s        = 8'($urandom);
      issue(is_write, a, d, s);
    end
    random_stall = 1'b0;
    bank_stall   = '0;
    drain();
  endtask

  initial begin
    void'($urandom(RANDOM_SEED));
    reset          = 1'b1;
    req            = 1'b0;
    we             = 1'b0;
    addr           = '0;
    wdata          = '0;
    strb           = '0;
    bank_stall     = '0;
    accepted_count = 0;
    response_count = 0;
    strict_latency = 1'b0;
    random_stall   = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_reset_state();
    fill_memory();
    test_full_word();
    test_partial_strobes();
    test_zero_strobe_banks();
    test_back_pressure();
    test_random_mix();

    if (exp_data_q.size() != 0) begin
      fail_now("responses were still outstanding at the end of the run");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// ==== banked_sram.f ====
+incdir+verif
verilog/banked_sram_pkg.sv
verilog/bank_if.sv
verilog/stream_fifo.sv
verilog/bank_splitter.sv
verilog/sram_bank.sv
verilog/banked_sram.sv
verif/banked_sram_tb.sv

// ==== Makefile ====
# Verilator build and run of the banked SRAM testbench.
# Every variable can be overridden on the command line, e.g. make sim TOP=...

VERILATOR   ?= verilator
TOP         ?= banked_sram_tb
FILELIST    ?= banked_sram.f
BUILD_DIR   ?= obj_dir
VERI_FLAGS  ?= --binary --timing -Wno-fatal -j 0
EXTRA_FLAGS ?=

.PHONY: sim clean

# the simulator exits with a non-zero status on $fatal, so make fails with it.
sim:
	$(VERILATOR) $(VERI_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
